//--- rtl/smartnic_pkg.sv
`default_nettype none

package smartnic_pkg;

    // per-packet metadata carried in tuser.
    typedef struct packed {
        logic [15:0] pid;
        logic        rss_enable;
        logic [11:0] rss_entropy;
        logic        hdr_tlast;
    } meta_t;

    // application destination field, 0 to 6 are literal ports.
    typedef enum logic [2:0] {
        DEST_PORT_0 = 3'd0,
        DEST_PORT_1 = 3'd1,
        DEST_PORT_2 = 3'd2,
        DEST_PORT_3 = 3'd3,
        DEST_PORT_4 = 3'd4,
        DEST_PORT_5 = 3'd5,
        DEST_PORT_6 = 3'd6,
        LOOPBACK    = 3'b111   // back to ingress port in tid.
    } dest_code_e;

    typedef enum logic {
        ARB_IDLE,
        ARB_PKT
    } arb_state_e;

    typedef enum logic {
        OUT_CMAC,
        OUT_HOST
    } out_sel_e;

endpackage

`default_nettype wire

//--- rtl/axis_pkg.sv
`default_nettype none

package axis_pkg;

    import smartnic_pkg::*;

    localparam int DATA_BYTES = 64;
    localparam int DATA_BITS  = DATA_BYTES * 8;

    typedef logic [2:0] port_t;

    // everything except valid/ready.
    typedef struct packed {
        logic [DATA_BITS-1:0]  tdata;
        logic [DATA_BYTES-1:0] tkeep;
        logic                  tlast;
        port_t                 tid;     // ingress port.
        port_t                 tdest;
        meta_t                 tuser;
    } axis_beat_t;

endpackage

`default_nettype wire

//--- rtl/axis_reg_slice.sv
`timescale 1ns/1ps
`default_nettype none

module axis_reg_slice
    import axis_pkg::*;
(
    input  logic       core_clk,
    input  logic       core_rstn,

    input  logic       in_valid,
    input  axis_beat_t in_beat,
    output logic       in_ready,

    output logic       out_valid,
    output axis_beat_t out_beat,
    input  logic       out_ready
);

    axis_beat_t skid_beat;
    logic       skid_valid;
    logic       load_main;
    logic       in_xfer;

    // main register free or draining this cycle.
    assign load_main = out_ready || !out_valid;
    assign in_xfer   = in_valid && in_ready;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            if (load_main) begin
                out_valid  <= skid_valid || in_xfer;
                skid_valid <= 1'b0;
                in_ready   <= 1'b1;
            end else if (in_xfer) begin
                // output stalled, park the beat.
                skid_valid <= 1'b1;
                in_ready   <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (load_main) begin
            out_beat <= skid_valid ? skid_beat : in_beat;
        end
        if (in_ready) begin
            skid_beat <= in_beat;   // only kept when main is stalled.
        end
    end

endmodule

`default_nettype wire

//--- rtl/app_port_demux.sv
`timescale 1ns/1ps
`default_nettype none

module app_port_demux
    import axis_pkg::*;
    import smartnic_pkg::*;
#(
    parameter int NUM_CMAC = 2
) (
    input  logic       core_clk,
    input  logic       core_rstn,

    input  logic       in_valid,
    input  axis_beat_t in_beat,
    output logic       in_ready,

    output logic       out_valid [NUM_CMAC],
    output axis_beat_t out_beat  [NUM_CMAC],
    input  logic       out_ready [NUM_CMAC]
);

    localparam int SEL_W = (NUM_CMAC > 1) ? $clog2(NUM_CMAC) : 1;

    port_t            resolved;
    axis_beat_t       beat_res;
    logic [SEL_W-1:0] sel_now;
    logic [SEL_W-1:0] sel_q;
    logic [SEL_W-1:0] sel;
    logic             in_pkt;

    // loopback goes home to the ingress port.
    assign resolved = (dest_code_e'(in_beat.tdest) == LOOPBACK) ? in_beat.tid : in_beat.tdest;
    assign sel_now  = (NUM_CMAC > 1) ? resolved[SEL_W-1:0] : '0;
    assign sel      = in_pkt ? sel_q : sel_now;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            in_pkt <= 1'b0;
            sel_q  <= '0;
        end else if (in_valid && in_ready) begin
            in_pkt <= !in_beat.tlast;
            if (!in_pkt) begin
                sel_q <= sel_now;   // hold route for the packet.
            end
        end
    end

    always_comb begin
        beat_res       = in_beat;
        beat_res.tdest = resolved;
    end

    always_comb begin
        for (int j = 0; j < NUM_CMAC; j++) begin
            out_valid[j] = in_valid && (sel == SEL_W'(j));
            out_beat[j]  = beat_res;
        end
        in_ready = out_ready[sel];
    end

endmodule

`default_nettype wire

//--- rtl/egress_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module egress_arbiter
    import axis_pkg::*;
    import smartnic_pkg::*;
#(
    parameter int NUM_SRC = 3
) (
    input  logic       core_clk,
    input  logic       core_rstn,

    input  logic       src_valid [NUM_SRC],
    input  axis_beat_t src_beat  [NUM_SRC],
    output logic       src_ready [NUM_SRC],

    output logic       out_valid,
    output axis_beat_t out_beat,
    input  logic       out_ready
);

    localparam int IDX_W = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;

    arb_state_e       state;
    logic [IDX_W-1:0] grant;
    logic [IDX_W-1:0] last_src;
    logic [IDX_W-1:0] pick;
    logic [IDX_W-1:0] cur;
    logic             pick_valid;
    logic             granted;
    logic             xfer;

    ////////////////////////////////////////////////////////////////////////////
    // round-robin pick, first valid source after the last one served.
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        int idx;
        pick       = last_src;
        pick_valid = 1'b0;
        for (int k = NUM_SRC; k >= 1; k--) begin
            idx = (int'(last_src) + k) % NUM_SRC;
            if (src_valid[idx]) begin
                pick       = IDX_W'(idx);  // nearest one wins.
                pick_valid = 1'b1;
            end
        end
    end

    assign cur       = (state == ARB_PKT) ? grant : pick;
    assign granted   = (state == ARB_PKT) || pick_valid;
    assign out_valid = granted && src_valid[cur];
    assign out_beat  = src_beat[cur];
    assign xfer      = out_valid && out_ready;

    always_comb begin
        for (int k = 0; k < NUM_SRC; k++) begin
            src_ready[k] = out_ready && granted && (cur == IDX_W'(k));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // grant state
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            state    <= ARB_IDLE;
            grant    <= '0;
            last_src <= IDX_W'(NUM_SRC - 1);
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_valid) begin
                        if (xfer && out_beat.tlast) begin
                            last_src <= pick;   // single-beat packet.
                        end else begin
                            // lock so the offered beat stays put.
                            state <= ARB_PKT;
                            grant <= pick;
                        end
                    end
                end
                ARB_PKT: begin
                    if (xfer && out_beat.tlast) begin
                        state    <= ARB_IDLE;
                        last_src <= grant;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/egress_out_demux.sv
`timescale 1ns/1ps
`default_nettype none

module egress_out_demux
    import axis_pkg::*;
    import smartnic_pkg::*;
(
    input  logic       core_clk,
    input  logic       core_rstn,

    input  out_sel_e   out_sel,

    input  logic       in_valid,
    input  axis_beat_t in_beat,
    output logic       in_ready,

    output logic       cmac_valid,
    output axis_beat_t cmac_beat,
    input  logic       cmac_ready,

    output logic       host_valid,
    output axis_beat_t host_beat,
    input  logic       host_ready
);

    out_sel_e sel_q;
    out_sel_e sel;
    logic     locked;   // packet has started.

    assign sel = locked ? sel_q : out_sel;

    // lock as soon as the first beat is offered, so it cannot swing
    // between outputs while it waits.
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            locked <= 1'b0;
            sel_q  <= OUT_CMAC;
        end else begin
            if (in_valid && in_ready && in_beat.tlast) begin
                locked <= 1'b0;
            end else if (in_valid) begin
                locked <= 1'b1;
            end
            if (!locked) begin
                sel_q <= out_sel;
            end
        end
    end

    assign cmac_valid = in_valid && (sel == OUT_CMAC);
    assign host_valid = in_valid && (sel == OUT_HOST);
    assign in_ready   = (sel == OUT_HOST) ? host_ready : cmac_ready;

    ////////////////////////////////////////////////////////////////////////////
    // metadata scrub
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        cmac_beat       = in_beat;
        cmac_beat.tuser = '0;          // mac sees no metadata.
    end

    always_comb begin
        host_beat                 = in_beat;
        host_beat.tuser.pid       = '0;
        host_beat.tuser.hdr_tlast = 1'b0;   // rss fields pass.
    end

endmodule

`default_nettype wire

//--- rtl/smartnic_demux.sv
`timescale 1ns/1ps
`default_nettype none

module smartnic_demux
    import axis_pkg::*;
    import smartnic_pkg::*;
#(
    parameter int NUM_CMAC = 2
) (
    input  logic       core_clk,
    input  logic       core_rstn,

    input  logic       bypass_valid [NUM_CMAC],
    input  axis_beat_t bypass_beat  [NUM_CMAC],
    output logic       bypass_ready [NUM_CMAC],

    input  logic       app_valid    [NUM_CMAC],
    input  axis_beat_t app_beat     [NUM_CMAC],
    output logic       app_ready    [NUM_CMAC],

    input  out_sel_e   out_sel      [NUM_CMAC],

    output logic       cmac_valid   [NUM_CMAC],
    output axis_beat_t cmac_beat    [NUM_CMAC],
    input  logic       cmac_ready   [NUM_CMAC],

    output logic       host_valid   [NUM_CMAC],
    output axis_beat_t host_beat    [NUM_CMAC],
    input  logic       host_ready   [NUM_CMAC]
);

    localparam int NUM_SRC = NUM_CMAC + 1;   // bypass plus every app demux.

    logic       app_s_valid [NUM_CMAC];
    axis_beat_t app_s_beat  [NUM_CMAC];
    logic       app_s_ready [NUM_CMAC];

    // [app source][egress port]
    logic       dmx_valid [NUM_CMAC][NUM_CMAC];
    axis_beat_t dmx_beat  [NUM_CMAC][NUM_CMAC];
    logic       dmx_ready [NUM_CMAC][NUM_CMAC];

    // [egress port][arbiter input], input 0 is bypass.
    logic       arb_valid [NUM_CMAC][NUM_SRC];
    axis_beat_t arb_beat  [NUM_CMAC][NUM_SRC];
    logic       arb_ready [NUM_CMAC][NUM_SRC];

    logic       egr_valid   [NUM_CMAC];
    axis_beat_t egr_beat    [NUM_CMAC];
    logic       egr_ready   [NUM_CMAC];
    logic       egr_p_valid [NUM_CMAC];
    axis_beat_t egr_p_beat  [NUM_CMAC];
    logic       egr_p_ready [NUM_CMAC];

    for (genvar i = 0; i < NUM_CMAC; i++) begin : g_port

        axis_reg_slice bypass_slice_i (
            .core_clk  (core_clk),
            .core_rstn (core_rstn),
            .in_valid  (bypass_valid[i]),
            .in_beat   (bypass_beat[i]),
            .in_ready  (bypass_ready[i]),
            .out_valid (arb_valid[i][0]),
            .out_beat  (arb_beat[i][0]),
            .out_ready (arb_ready[i][0])
        );

        axis_reg_slice app_slice_i (
            .core_clk  (core_clk),
            .core_rstn (core_rstn),
            .in_valid  (app_valid[i]),
            .in_beat   (app_beat[i]),
            .in_ready  (app_ready[i]),
            .out_valid (app_s_valid[i]),
            .out_beat  (app_s_beat[i]),
            .out_ready (app_s_ready[i])
        );

        app_port_demux #(.NUM_CMAC(NUM_CMAC)) app_demux_i (
            .core_clk  (core_clk),
            .core_rstn (core_rstn),
            .in_valid  (app_s_valid[i]),
            .in_beat   (app_s_beat[i]),
            .in_ready  (app_s_ready[i]),
            .out_valid (dmx_valid[i]),
            .out_beat  (dmx_beat[i]),
            .out_ready (dmx_ready[i])
        );

        // app demux i feeds input i+1 of every arbiter.
        for (genvar j = 0; j < NUM_CMAC; j++) begin : g_cross
            assign arb_valid[j][i+1] = dmx_valid[i][j];
            assign arb_beat[j][i+1]  = dmx_beat[i][j];
            assign dmx_ready[i][j]   = arb_ready[j][i+1];
        end

        egress_arbiter #(.NUM_SRC(NUM_SRC)) arbiter_i (
            .core_clk  (core_clk),
            .core_rstn (core_rstn),
            .src_valid (arb_valid[i]),
            .src_beat  (arb_beat[i]),
            .src_ready (arb_ready[i]),
            .out_valid (egr_valid[i]),
            .out_beat  (egr_beat[i]),
            .out_ready (egr_ready[i])
        );

        axis_reg_slice egress_slice_i (
            .core_clk  (core_clk),
            .core_rstn (core_rstn),
            .in_valid  (egr_valid[i]),
            .in_beat   (egr_beat[i]),
            .in_ready  (egr_ready[i]),
            .out_valid (egr_p_valid[i]),
            .out_beat  (egr_p_beat[i]),
            .out_ready (egr_p_ready[i])
        );

        egress_out_demux out_demux_i (
            .core_clk   (core_clk),
            .core_rstn  (core_rstn),
            .out_sel    (out_sel[i]),
            .in_valid   (egr_p_valid[i]),
            .in_beat    (egr_p_beat[i]),
            .in_ready   (egr_p_ready[i]),
            .cmac_valid (cmac_valid[i]),
            .cmac_beat  (cmac_beat[i]),
            .cmac_ready (cmac_ready[i]),
            .host_valid (host_valid[i]),
            .host_beat  (host_beat[i]),
            .host_ready (host_ready[i])
        );

    end

endmodule

`default_nettype wire

//--- testbench/smartnic_demux_tb.sv
`timescale 1ns/1ps
`default_nettype none

module smartnic_demux_tb
    import axis_pkg::*;
    import smartnic_pkg::*;
();

    localparam int NUM_CMAC  = 2;
    localparam int N_STREAMS = 4;    // bypass 0, bypass 1, app 0, app 1.
    localparam int NUM_PKTS  = 40;   // per stream.

    logic       core_clk = 1'b0;
    logic       core_rstn;
    logic       bypass_valid [NUM_CMAC];
    axis_beat_t bypass_beat  [NUM_CMAC];
    logic       bypass_ready [NUM_CMAC];
    logic       app_valid    [NUM_CMAC];
    axis_beat_t app_beat     [NUM_CMAC];
    logic       app_ready    [NUM_CMAC];
    out_sel_e   out_sel      [NUM_CMAC];
    logic       cmac_valid   [NUM_CMAC];
    axis_beat_t cmac_beat    [NUM_CMAC];
    logic       cmac_ready   [NUM_CMAC];
    logic       host_valid   [NUM_CMAC];
    axis_beat_t host_beat    [NUM_CMAC];
    logic       host_ready   [NUM_CMAC];

    axis_beat_t stim_q [N_STREAMS][$];
    axis_beat_t exp_q  [NUM_CMAC][N_STREAMS][$];   // raw beats by egress port, stream.
    int         rd_ptr [NUM_CMAC][N_STREAMS];
    int         cur_src    [NUM_CMAC];
    logic       offered    [NUM_CMAC];
    logic       first_beat [NUM_CMAC];
    out_sel_e   start_sel  [NUM_CMAC];
    int         cycle_cnt   = 0;
    int         cycle_limit = 200;

    smartnic_demux #(.NUM_CMAC(NUM_CMAC)) dut_i (
        .core_clk     (core_clk),
        .core_rstn    (core_rstn),
        .bypass_valid (bypass_valid),
        .bypass_beat  (bypass_beat),
        .bypass_ready (bypass_ready),
        .app_valid    (app_valid),
        .app_beat     (app_beat),
        .app_ready    (app_ready),
        .out_sel      (out_sel),
        .cmac_valid   (cmac_valid),
        .cmac_beat    (cmac_beat),
        .cmac_ready   (cmac_ready),
        .host_valid   (host_valid),
        .host_beat    (host_beat),
        .host_ready   (host_ready)
    );

    always #2 core_clk = ~core_clk;

    always @(posedge core_clk) cycle_cnt <= cycle_cnt + 1;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] st);
        return {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};   // taps 32 22 2 1.
    endfunction

    function automatic logic [31:0] rand_bits(inout logic [31:0] st, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_step(st);
            v  = {v[30:0], st[0]};
        end
        return v;
    endfunction

    // expected egress port, output side and scrubbed beat.
    function automatic void ref_model(input int src, input axis_beat_t raw, input out_sel_e sel,
                                      output int port, output logic to_host,
                                      output axis_beat_t exp_b);
        exp_b = raw;
        if (src >= NUM_CMAC && raw.tdest == port_t'(LOOPBACK)) begin
            exp_b.tdest = raw.tid;
        end
        port    = (src < NUM_CMAC) ? src : int'(exp_b.tdest) % NUM_CMAC;
        to_host = (sel == OUT_HOST);
        if (to_host) begin
            exp_b.tuser.pid       = '0;
            exp_b.tuser.hdr_tlast = 1'b0;
        end else begin
            exp_b.tuser = '0;
        end
    endfunction

    function automatic logic all_drained();
        for (int p = 0; p < NUM_CMAC; p++) begin
            for (int s = 0; s < N_STREAMS; s++) begin
                if (rd_ptr[p][s] != exp_q[p][s].size()) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [511:0] act,
                             input logic [511:0] expv);
        if (act !== expv) begin
            report_failure($sformatf("FAIL time=%0t signal=%s got=%0h expected=%0h",
                                     $time, name, act, expv));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stream drivers
    ////////////////////////////////////////////////////////////////////////////
    for (genvar s = 0; s < N_STREAMS; s++) begin : g_src
        logic       valid;
        axis_beat_t beat;
        logic       rdy;
        if (s < NUM_CMAC) begin : g_bypass
            assign bypass_valid[s] = valid;
            assign bypass_beat[s]  = beat;
            assign rdy             = bypass_ready[s];
        end else begin : g_app
            assign app_valid[s-NUM_CMAC] = valid;
            assign app_beat[s-NUM_CMAC]  = beat;
            assign rdy                   = app_ready[s-NUM_CMAC];
        end
        initial begin
            valid <= 1'b0;
            beat  <= '0;
            wait (core_rstn === 1'b1);
            @(posedge core_clk);
            for (int k = 0; k < stim_q[s].size(); k++) begin
                valid <= 1'b1;
                beat  <= stim_q[s][k];
                @(posedge core_clk);
                while (!rdy) @(posedge core_clk);   // hold until it transfers.
            end
            valid <= 1'b0;
        end
    end

    // random back-pressure and out_sel toggling, mid-packet too.
    initial begin
        logic [31:0] st;
        st = 32'h5689;
        repeat (97) st = lfsr_step(st);
        for (int p = 0; p < NUM_CMAC; p++) begin
            cmac_ready[p] <= 1'b0;
            host_ready[p] <= 1'b0;
            out_sel[p]    <= OUT_CMAC;
        end
        forever begin
            @(posedge core_clk);
            for (int p = 0; p < NUM_CMAC; p++) begin
                cmac_ready[p] <= (rand_bits(st, 2) != 32'd0);
                host_ready[p] <= (rand_bits(st, 2) != 32'd0);
                if (rand_bits(st, 4) == 32'd15) begin
                    out_sel[p] <= (out_sel[p] == OUT_HOST) ? OUT_CMAC : OUT_HOST;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output checker
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge core_clk) begin
        axis_beat_t act;
        axis_beat_t exp_b;
        logic       to_host;
        int         port;
        int         s;
        string      nm;
        for (int p = 0; p < NUM_CMAC; p++) begin
            if (!core_rstn) begin
                offered[p]    = 1'b0;
                first_beat[p] = 1'b1;
                cur_src[p]    = 0;
                for (int k = 0; k < N_STREAMS; k++) rd_ptr[p][k] = 0;
            end else begin
                // level the DUT sees while the first beat is offered.
                if ((cmac_valid[p] || host_valid[p]) && !offered[p]) begin
                    offered[p]   = 1'b1;
                    start_sel[p] = out_sel[p];
                end
                if ((cmac_valid[p] && cmac_ready[p]) || (host_valid[p] && host_ready[p])) begin
                    act = host_valid[p] ? host_beat[p] : cmac_beat[p];
                    nm  = host_valid[p] ? $sformatf("host_beat[%0d]", p)
                                        : $sformatf("cmac_beat[%0d]", p);
                    if (first_beat[p]) begin
                        if (act.tdata[7:0] > 8'd3) begin
                            report_failure($sformatf("%s carried an unknown stream tag", nm));
                        end
                        cur_src[p] = int'(act.tdata[7:0]);
                    end
                    s = cur_src[p];
                    if (rd_ptr[p][s] >= exp_q[p][s].size()) begin
                        report_failure(
                            $sformatf("port %0d delivered more beats of stream %0d than sent",
                                      p, s));
                    end
                    ref_model(s, exp_q[p][s][rd_ptr[p][s]], start_sel[p], port, to_host, exp_b);
                    check_val($sformatf("host_valid[%0d]", p), 512'(host_valid[p]), 512'(to_host));
                    check_val({nm, ".tdata"}, act.tdata, exp_b.tdata);
                    check_val({nm, ".tkeep"}, 512'(act.tkeep), 512'(exp_b.tkeep));
                    check_val({nm, ".tlast"}, 512'(act.tlast), 512'(exp_b.tlast));
                    check_val({nm, ".tid"}, 512'(act.tid), 512'(exp_b.tid));
                    check_val({nm, ".tdest"}, 512'(act.tdest), 512'(exp_b.tdest));
                    check_val({nm, ".tuser"}, 512'(act.tuser), 512'(exp_b.tuser));
                    rd_ptr[p][s]  = rd_ptr[p][s] + 1;
                    first_beat[p] = act.tlast;
                    if (act.tlast) begin
                        offered[p] = 1'b0;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus build, reset, end of run
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] st;
        logic [31:0] r;
        axis_beat_t  hdr;
        axis_beat_t  beat;
        axis_beat_t  exp_b;
        logic        to_host;
        logic        timed_out;
        int          len;
        int          port;
        int          total;
        core_rstn <= 1'b0;
        st    = 32'h5689;
        total = 0;
        hdr   = '0;
        for (int s = 0; s < N_STREAMS; s++) begin
            for (int n = 0; n < NUM_PKTS; n++) begin
                len       = 1 + int'(rand_bits(st, 2));
                hdr.tid   = (s < NUM_CMAC) ? port_t'(s) : port_t'(rand_bits(st, 1));
                hdr.tdest = (rand_bits(st, 2) == 32'd0) ? port_t'(LOOPBACK)
                                                        : port_t'(rand_bits(st, 3));
                r         = rand_bits(st, 30);
                hdr.tuser = r[29:0];
                ref_model(s, hdr, OUT_CMAC, port, to_host, exp_b);
                for (int b = 0; b < len; b++) begin
                    beat = hdr;
                    for (int w = 0; w < DATA_BITS / 32; w++) begin
                        beat.tdata[w*32 +: 32] = rand_bits(st, 32);
                    end
                    beat.tkeep = {rand_bits(st, 32), rand_bits(st, 32)};
                    beat.tlast = (b == len - 1);
                    if (b == 0) begin
                        beat.tdata[23:0] = {n[15:0], s[7:0]};   // sequence and stream tag.
                    end
                    stim_q[s].push_back(beat);
                    exp_q[port][s].push_back(beat);
                end
                total += len;
            end
        end
        cycle_limit = 8 * total + 200;
        repeat (8) @(posedge core_clk);
        core_rstn <= 1'b1;
        while (!all_drained() && cycle_cnt < cycle_limit) @(negedge core_clk);
        timed_out = !all_drained();
        repeat (20) @(negedge core_clk);   // stray beats would show up here.
        if (timed_out) begin
            for (int p = 0; p < NUM_CMAC; p++) begin
                for (int s = 0; s < N_STREAMS; s++) begin
                    if (rd_ptr[p][s] != exp_q[p][s].size()) begin
                        $display("queue of port %0d stream %0d still holds %0d beats",
                                 p, s, exp_q[p][s].size() - rd_ptr[p][s]);
                    end
                end
            end
            report_failure("timeout, the outputs stopped delivering packets");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- smartnic_demux.f
rtl/smartnic_pkg.sv
rtl/axis_pkg.sv
rtl/axis_reg_slice.sv
rtl/app_port_demux.sv
rtl/egress_arbiter.sv
rtl/egress_out_demux.sv
rtl/smartnic_demux.sv
testbench/smartnic_demux_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --top-module smartnic_demux_tb -f smartnic_demux.f \
    && ./obj_dir/Vsmartnic_demux_tb | tee /dev/stderr | grep -q "Test passed" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
